// File: Bender.yml
package:
  name: fpu_apb

sources:
  - hdl/fp_format_pkg.sv
  - hdl/fpu_regmap_pkg.sv
  - hdl/fpu_apb_regs.sv
  - hdl/fpu_ctrl_fsm.sv
  - hdl/fpu_step_counter.sv
  - hdl/fpu_add_path.sv
  - hdl/fpu_mul_path.sv
  - hdl/fpu_normalize.sv
  - hdl/fpu_top.sv
  - target: simulation
    files:
      - sim/fpu_sva.sv
      - sim/fpu_tb.sv

// File: compile.f
hdl/fp_format_pkg.sv
hdl/fpu_regmap_pkg.sv
hdl/fpu_apb_regs.sv
hdl/fpu_ctrl_fsm.sv
hdl/fpu_step_counter.sv
hdl/fpu_add_path.sv
hdl/fpu_mul_path.sv
hdl/fpu_normalize.sv
hdl/fpu_top.sv
sim/fpu_sva.sv
sim/fpu_tb.sv

// File: hdl/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int SIG_W    = FRAC_W + 1;
    localparam int WORD_W   = 1 + EXP_W + FRAC_W;
    localparam int EXP_BIAS = 127;

    // Wide enough to hold SIG_W itself.
    localparam int CNT_W    = $clog2(SIG_W + 1);

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp_fields_t;

    // The same word seen as bus data or as float fields.
    typedef union packed {
        logic [WORD_W-1:0] raw;
        fp_fields_t        f;
    } fp_word_u;

endpackage

`default_nettype wire

// File: hdl/fpu_add_path.sv
`default_nettype none

module fpu_add_path (
    input  logic                             clk,
    input  logic                             rst,
    input  fp_format_pkg::fp_word_u          op_a,
    input  fp_format_pkg::fp_word_u          op_b,
    input  logic                             align_en,
    input  logic                             sum_en,
    input  logic                             negate_b,
    output logic [fp_format_pkg::SIG_W:0]    sum_mag,
    output logic                             sum_sign,
    output logic [fp_format_pkg::EXP_W-1:0]  sum_exp
);

    import fp_format_pkg::*;

    logic [SIG_W-1:0] sig_a;
    logic [SIG_W-1:0] sig_b;
    logic [EXP_W-1:0] diff_ab;
    logic [EXP_W-1:0] diff_ba;
    logic [SIG_W-1:0] al_a;
    logic [SIG_W-1:0] al_b;
    logic             al_sign_a;
    logic             al_sign_b;

    // A zero exponent reads as a zero significand.
    assign sig_a   = (op_a.f.exp == '0) ? '0 : {1'b1, op_a.f.frac};
    assign sig_b   = (op_b.f.exp == '0) ? '0 : {1'b1, op_b.f.frac};
    assign diff_ab = op_a.f.exp - op_b.f.exp;
    assign diff_ba = op_b.f.exp - op_a.f.exp;

    always_ff @(posedge clk) begin
        if (rst) begin
            al_a      <= '0;
            al_b      <= '0;
            al_sign_a <= 1'b0;
            al_sign_b <= 1'b0;
            sum_exp   <= '0;
            sum_mag   <= '0;
            sum_sign  <= 1'b0;
        end else if (align_en) begin
            al_sign_a <= op_a.f.sign;
            al_sign_b <= op_b.f.sign ^ negate_b;
            if (op_a.f.exp >= op_b.f.exp) begin
                al_a    <= sig_a;
                al_b    <= sig_b >> diff_ab;
                sum_exp <= op_a.f.exp;
            end else begin
                al_a    <= sig_a >> diff_ba;
                al_b    <= sig_b;
                sum_exp <= op_b.f.exp;
            end
        end else if (sum_en) begin
            if (al_sign_a == al_sign_b) begin
                sum_mag  <= {1'b0, al_a} + {1'b0, al_b};
                sum_sign <= al_sign_a;
            end else if (al_a >= al_b) begin
                sum_mag  <= {1'b0, al_a - al_b};
                sum_sign <= al_sign_a;
            end else begin
                sum_mag  <= {1'b0, al_b - al_a};
                sum_sign <= al_sign_b;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fpu_apb_regs.sv
`default_nettype none

module fpu_apb_regs (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [fpu_regmap_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [31:0]                           pwdata,
    output logic [31:0]                           prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output fp_format_pkg::fp_word_u               op_a,
    output fp_format_pkg::fp_word_u               op_b,
    output logic [fpu_regmap_pkg::OP_W-1:0]       op,
    output logic                                  start,
    input  logic                                  busy,
    input  fp_format_pkg::fp_word_u               result
);

    import fpu_regmap_pkg::*;

    logic access;
    logic busy_any;
    logic rd_result;
    logic wr_operand;
    logic bad_opcode;
    logic wr_ok;

    assign access   = psel && penable;
    assign busy_any = busy || start;

    // RESULT reads wait until the running operation has finished.
    assign rd_result = access && !pwrite && (paddr == ADDR_RESULT);
    assign pready    = !(rd_result && busy_any);

    assign wr_operand = (paddr == ADDR_OP_A) || (paddr == ADDR_OP_B) || (paddr == ADDR_CTRL);
    assign bad_opcode = (paddr == ADDR_CTRL) && (pwdata[OP_W-1:0] > OP_MUL);
    assign pslverr    = access && pwrite && ((wr_operand && busy_any) || bad_opcode);
    assign wr_ok      = access && pwrite && !pslverr;

    //////////////////////////////
    // Register file.
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            op_a  <= '0;
            op_b  <= '0;
            op    <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_ok) begin
                case (paddr)
                    ADDR_OP_A: op_a.raw <= pwdata;
                    ADDR_OP_B: op_b.raw <= pwdata;
                    ADDR_CTRL: begin
                        op    <= pwdata[OP_W-1:0];
                        start <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Unmapped offsets read as zero.
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                ADDR_OP_A:   prdata = op_a.raw;
                ADDR_OP_B:   prdata = op_b.raw;
                ADDR_CTRL:   prdata[OP_W-1:0] = op;
                ADDR_STATUS: prdata[STATUS_BUSY_BIT] = busy;
                ADDR_RESULT: prdata = result.raw;
                default:     prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/fpu_ctrl_fsm.sv
`default_nettype none

module fpu_ctrl_fsm (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic [fpu_regmap_pkg::OP_W-1:0] op,
    output logic                            busy,
    output logic                            align_en,
    output logic                            sum_en,
    output logic                            negate_b,
    output logic                            mul_load,
    output logic                            mul_step,
    output logic                            cnt_load,
    output logic                            cnt_en,
    output logic                            norm_load,
    output logic                            norm_src,
    output logic                            norm_step,
    input  logic                            cnt_done,
    input  logic                            norm_done
);

    import fpu_regmap_pkg::*;

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_ALIGN     = 3'd1;
    localparam logic [2:0] ST_SUM       = 3'd2;
    localparam logic [2:0] ST_MUL_LOAD  = 3'd3;
    localparam logic [2:0] ST_MUL_RUN   = 3'd4;
    localparam logic [2:0] ST_NORM_LOAD = 3'd5;
    localparam logic [2:0] ST_NORM      = 3'd6;

    logic [2:0] state;
    logic [2:0] state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = (op == OP_MUL) ? ST_MUL_LOAD : ST_ALIGN;
                end
            end
            ST_ALIGN:     state_next = ST_SUM;
            ST_SUM:       state_next = ST_NORM_LOAD;
            ST_MUL_LOAD:  state_next = ST_MUL_RUN;
            ST_MUL_RUN:   if (cnt_done) state_next = ST_NORM_LOAD;
            ST_NORM_LOAD: state_next = ST_NORM;
            ST_NORM:      if (norm_done) state_next = ST_IDLE;
            default:      state_next = ST_IDLE;
        endcase
    end

    assign busy = (state != ST_IDLE);

    // Add branch.
    assign align_en = (state == ST_ALIGN);
    assign sum_en   = (state == ST_SUM);
    assign negate_b = (op == OP_SUB);

    // The step counter paces the multiply branch.
    assign mul_load = (state == ST_MUL_LOAD);
    assign cnt_load = (state == ST_MUL_LOAD);
    assign mul_step = (state == ST_MUL_RUN) && !cnt_done;
    assign cnt_en   = (state == ST_MUL_RUN) && !cnt_done;

    assign norm_load = (state == ST_NORM_LOAD);
    assign norm_src  = (op == OP_MUL);
    assign norm_step = (state == ST_NORM);

endmodule

`default_nettype wire

// File: hdl/fpu_mul_path.sv
`default_nettype none

module fpu_mul_path (
    input  logic                             clk,
    input  logic                             rst,
    input  fp_format_pkg::fp_word_u          op_a,
    input  fp_format_pkg::fp_word_u          op_b,
    input  logic                             load,
    input  logic                             step,
    output logic [fp_format_pkg::SIG_W:0]    prod_hi,
    output logic                             prod_sign,
    output logic [fp_format_pkg::EXP_W-1:0]  prod_exp
);

    import fp_format_pkg::*;

    logic                 zero_in;
    logic [EXP_W:0]       exp_sum;
    logic [SIG_W-1:0]     mcand;
    logic [2*SIG_W-1:0]   prod;
    logic [SIG_W:0]       partial;

    assign zero_in = (op_a.f.exp == '0) || (op_b.f.exp == '0);
    assign exp_sum = {1'b0, op_a.f.exp} + {1'b0, op_b.f.exp} - (EXP_W+1)'(EXP_BIAS);

    // Upper half plus multiplicand when the low multiplier bit is set.
    assign partial = {1'b0, prod[2*SIG_W-1:SIG_W]} + (prod[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            mcand     <= '0;
            prod      <= '0;
            prod_sign <= 1'b0;
            prod_exp  <= '0;
        end else if (load) begin
            mcand     <= zero_in ? '0 : {1'b1, op_a.f.frac};
            prod      <= {{SIG_W{1'b0}}, (zero_in ? {SIG_W{1'b0}} : {1'b1, op_b.f.frac})};
            prod_sign <= op_a.f.sign ^ op_b.f.sign;
            prod_exp  <= exp_sum[EXP_W-1:0];
        end else if (step) begin
            prod <= {partial, prod[SIG_W-1:1]};
        end
    end

    assign prod_hi = prod[2*SIG_W-1:SIG_W-1];

endmodule

`default_nettype wire

// File: hdl/fpu_normalize.sv
`default_nettype none

module fpu_normalize (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load,
    input  logic                             src,
    input  logic                             step,
    input  logic [fp_format_pkg::SIG_W:0]    add_mag,
    input  logic [fp_format_pkg::SIG_W:0]    mul_mag,
    input  logic                             add_sign,
    input  logic                             mul_sign,
    input  logic [fp_format_pkg::EXP_W-1:0]  add_exp,
    input  logic [fp_format_pkg::EXP_W-1:0]  mul_exp,
    output logic                             done,
    output fp_format_pkg::fp_word_u          result
);

    import fp_format_pkg::*;

    logic [SIG_W:0]   mant;
    logic [EXP_W-1:0] exp_q;
    logic             sign_q;

    // Top bit is the carry, the one below it the hidden bit.
    assign done = (mant == '0) || (!mant[SIG_W] && mant[SIG_W-1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            mant   <= '0;
            exp_q  <= '0;
            sign_q <= 1'b0;
        end else if (load) begin
            mant   <= src ? mul_mag : add_mag;
            exp_q  <= src ? mul_exp : add_exp;
            sign_q <= src ? mul_sign : add_sign;
        end else if (step && !done) begin
            if (mant[SIG_W]) begin
                mant  <= {1'b0, mant[SIG_W:1]};
                exp_q <= exp_q + 1'b1;
            end else begin
                mant  <= {mant[SIG_W-1:0], 1'b0};
                exp_q <= exp_q - 1'b1;
            end
        end
    end

    // A zero mantissa always packs as +0.
    always_comb begin
        result = '0;
        if (mant != '0) begin
            result.f.sign = sign_q;
            result.f.exp  = exp_q;
            result.f.frac = mant[FRAC_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/fpu_regmap_pkg.sv
`default_nettype none

package fpu_regmap_pkg;

    localparam int APB_ADDR_W = 5;

    localparam logic [APB_ADDR_W-1:0] ADDR_OP_A   = 5'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_OP_B   = 5'h04;
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 5'h08;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 5'h0C;
    localparam logic [APB_ADDR_W-1:0] ADDR_RESULT = 5'h10;

    localparam int OP_W = 2;

    localparam logic [OP_W-1:0] OP_ADD = 2'd0;
    localparam logic [OP_W-1:0] OP_SUB = 2'd1;
    localparam logic [OP_W-1:0] OP_MUL = 2'd2;

    localparam int STATUS_BUSY_BIT = 0;

endpackage

`default_nettype wire

// File: hdl/fpu_step_counter.sv
`default_nettype none

module fpu_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic en,
    output logic done
);

    import fp_format_pkg::*;

    logic [CNT_W-1:0] count;

    // One multiply step per significand bit.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(SIG_W);
        end else if (en && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    assign done = (count == '0);

endmodule

`default_nettype wire

// File: hdl/fpu_top.sv
`default_nettype none

module fpu_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [fpu_regmap_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [31:0]                           pwdata,
    output logic [31:0]                           prdata,
    output logic                                  pready,
    output logic                                  pslverr
);

    import fp_format_pkg::*;
    import fpu_regmap_pkg::*;

    fp_word_u         op_a;
    fp_word_u         op_b;
    fp_word_u         result;
    logic [OP_W-1:0]  op;
    logic             start;
    logic             busy;

    logic align_en;
    logic sum_en;
    logic negate_b;
    logic mul_load;
    logic mul_step;
    logic cnt_load;
    logic cnt_en;
    logic cnt_done;
    logic norm_load;
    logic norm_src;
    logic norm_step;
    logic norm_done;

    logic [SIG_W:0]   sum_mag;
    logic             sum_sign;
    logic [EXP_W-1:0] sum_exp;
    logic [SIG_W:0]   prod_hi;
    logic             prod_sign;
    logic [EXP_W-1:0] prod_exp;

    //////////////////////////////
    // Bus side and sequencing.
    //////////////////////////////

    fpu_apb_regs u_regs (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .op_a(op_a), .op_b(op_b), .op(op), .start(start),
        .busy(busy), .result(result)
    );

    fpu_ctrl_fsm u_ctrl (
        .clk(clk), .rst(rst), .start(start), .op(op), .busy(busy),
        .align_en(align_en), .sum_en(sum_en), .negate_b(negate_b),
        .mul_load(mul_load), .mul_step(mul_step),
        .cnt_load(cnt_load), .cnt_en(cnt_en),
        .norm_load(norm_load), .norm_src(norm_src), .norm_step(norm_step),
        .cnt_done(cnt_done), .norm_done(norm_done)
    );

    fpu_step_counter u_cnt (
        .clk(clk), .rst(rst), .load(cnt_load), .en(cnt_en), .done(cnt_done)
    );

    //////////////////////////////
    // Datapaths.
    //////////////////////////////

    fpu_add_path u_add (
        .clk(clk), .rst(rst), .op_a(op_a), .op_b(op_b),
        .align_en(align_en), .sum_en(sum_en), .negate_b(negate_b),
        .sum_mag(sum_mag), .sum_sign(sum_sign), .sum_exp(sum_exp)
    );

    fpu_mul_path u_mul (
        .clk(clk), .rst(rst), .op_a(op_a), .op_b(op_b),
        .load(mul_load), .step(mul_step),
        .prod_hi(prod_hi), .prod_sign(prod_sign), .prod_exp(prod_exp)
    );

    fpu_normalize u_norm (
        .clk(clk), .rst(rst),
        .load(norm_load), .src(norm_src), .step(norm_step),
        .add_mag(sum_mag), .mul_mag(prod_hi),
        .add_sign(sum_sign), .mul_sign(prod_sign),
        .add_exp(sum_exp), .mul_exp(prod_exp),
        .done(norm_done), .result(result)
    );

endmodule

`default_nettype wire

// File: sim/fpu_sva.sv
`default_nettype none

module fpu_apb_sva (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic start,
    input logic busy
);

    timeunit 1ns;
    timeprecision 1ps;

    // Errors only complete an access.
    a_err_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable && pready))
        else $error("pslverr outside a completing access cycle");

    a_ready_when_idle: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !busy) |-> pready)
        else $error("access stalled while the FPU is idle");

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("start raised while an operation is running");

endmodule

bind fpu_apb_regs fpu_apb_sva u_sva (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .start(start),
    .busy(busy)
);

`default_nettype wire

// File: sim/fpu_tb.sv
`default_nettype none

module fpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import fpu_regmap_pkg::*;

    localparam int NUM_CASES   = 13;
    localparam int CLK_PERIOD  = 100;
    localparam int WATCHDOG_NS = (NUM_CASES * 60 + 200) * CLK_PERIOD;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    logic [OP_W-1:0] case_op  [NUM_CASES];
    logic [31:0]     case_a   [NUM_CASES];
    logic [31:0]     case_b   [NUM_CASES];
    logic [31:0]     case_res [NUM_CASES];
    logic            case_err [NUM_CASES];

    fpu_top dut0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // Runs one APB transfer and samples the response at the falling edge.
    task automatic transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int waits);
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits = waits + 1;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        logic        err;
        int          waits;
        transfer(1'b1, addr, data, unused, err, waits);
        check("pslverr", err, exp_err);
    endtask

    task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
        logic err;
        int   waits;
        transfer(1'b0, addr, 32'h0, data, err, waits);
        check("pslverr", err, 1'b0);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        status = 32'h1;
        while (status[STATUS_BUSY_BIT]) begin
            read_reg(ADDR_STATUS, status);
        end
    endtask

    task automatic set_case(input int idx, input logic [OP_W-1:0] op, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] res, input logic err);
        case_op[idx]  = op;
        case_a[idx]   = a;
        case_b[idx]   = b;
        case_res[idx] = res;
        case_err[idx] = err;
    endtask

    task automatic fill_table();
        set_case(0,  OP_ADD, 32'h3FC00000, 32'h40100000, 32'h40700000, 1'b0); // 1.5 + 2.25
        set_case(1,  OP_ADD, 32'h40A00000, 32'hBFA00000, 32'h40700000, 1'b0); // 5.0 + -1.25
        set_case(2,  OP_ADD, 32'h3FE00000, 32'h3FC00000, 32'h40500000, 1'b0); // 1.75 + 1.5
        set_case(3,  OP_ADD, 32'hBF800000, 32'hC0000000, 32'hC0400000, 1'b0); // -1 + -2
        set_case(4,  OP_SUB, 32'h3FC00000, 32'h3FA00000, 32'h3E800000, 1'b0); // 1.5 - 1.25
        set_case(5,  OP_SUB, 32'h3F810000, 32'h3F800000, 32'h3C000000, 1'b0); // 7 left shifts
        set_case(6,  OP_SUB, 32'h40000000, 32'h40000000, 32'h00000000, 1'b0);
        set_case(7,  OP_SUB, 32'h3F800000, 32'h40400000, 32'hC0000000, 1'b0); // 1 - 3
        set_case(8,  OP_MUL, 32'h40400000, 32'hC0200000, 32'hC0F00000, 1'b0); // 3 * -2.5
        set_case(9,  OP_MUL, 32'h3FC00000, 32'h3FC00000, 32'h40100000, 1'b0); // carry
        set_case(10, OP_MUL, 32'hC0000000, 32'h00000000, 32'h00000000, 1'b0);
        set_case(11, OP_MUL, 32'h40000000, 32'h3F000000, 32'h3F800000, 1'b0); // 2 * 0.5
        set_case(12, 2'd3,   32'h3F800000, 32'h3F800000, 32'h00000000, 1'b1);
    endtask

    task automatic run_case(input int idx);
        logic [31:0] data;
        write_reg(ADDR_OP_A, case_a[idx], 1'b0);
        write_reg(ADDR_OP_B, case_b[idx], 1'b0);
        write_reg(ADDR_CTRL, 32'(case_op[idx]), case_err[idx]);
        if (case_err[idx]) begin
            // A rejected opcode leaves the sequencer idle.
            read_reg(ADDR_STATUS, data);
            check("status", data, 32'h0);
        end else begin
            wait_idle();
            read_reg(ADDR_RESULT, data);
            check($sformatf("result[%0d]", idx), data, case_res[idx]);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the FPU did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] data;
        logic        err;
        int          waits;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        fill_table();

        read_reg(ADDR_STATUS, data);
        check("status", data, 32'h0);
        read_reg(ADDR_OP_A, data);
        check("op_a", data, 32'h0);
        read_reg(ADDR_RESULT, data);
        check("result", data, 32'h0);

        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end

        ////////////////////////////////
        // Back-pressure and busy writes.
        ////////////////////////////////
        write_reg(ADDR_OP_A, 32'h3FC00000, 1'b0);
        write_reg(ADDR_OP_B, 32'h40100000, 1'b0);
        write_reg(ADDR_CTRL, 32'(OP_MUL), 1'b0);
        transfer(1'b0, ADDR_RESULT, 32'h0, data, err, waits);
        check("pslverr", err, 1'b0);
        check("result", data, 32'h40580000);
        check("result_stall", waits > 0, 1'b1);

        write_reg(ADDR_OP_B, 32'hC0200000, 1'b0);
        write_reg(ADDR_CTRL, 32'(OP_MUL), 1'b0);
        write_reg(ADDR_OP_A, 32'h12345678, 1'b1);
        wait_idle();
        read_reg(ADDR_OP_A, data);
        check("op_a", data, 32'h3FC00000);
        read_reg(ADDR_RESULT, data);
        check("result", data, 32'hC0700000); // 1.5 * -2.5

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
